// ==== host_chan_stimulus.txt ====
# op addr data expect, all hex; op W = MMIO write, R = MMIO read, M = host memory response
# expect is the read data for R lines and is unused for W and M lines
R 0000 00000000 48434d31
W 0008 a5a50001 00000000
W 000c 12345678 00000000
R 0008 00000000 a5a50001
W 0000 deadbeef 00000000
W 0004 deadbeef 00000000
R 0000 00000000 48434d31
R 0040 00000000 00000000
M 0000 11112222 00000000
M 0000 33334444 00000000
M 0000 55556666 00000000
R 0004 00000000 00000003
W 0010 cafef00d 00000000
W 0014 0badc0de 00000000
R 0010 00000000 cafef00d
R 0014 00000000 0badc0de
R 0008 00000000 a5a50001
R 000c 00000000 12345678
R 0000 00000000 48434d31
R 0004 00000000 00000003

// ==== sim.f ====
host_chan_pkg.sv
axil_reg_stage.sv
host_chan_split_mmio.sv
host_chan_map_mmio_axil.sv
afu_csr_regs.sv
host_chan_as_axil_mmio.sv
tb_host_chan_sva.sv
tb_host_chan.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the host channel shim testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_host_chan -o tb_host_chan
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_host_chan)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// ==== tb_host_chan.sv ====
/*
 * Testbench for the host channel shim that replays the stimulus file
 * and scoreboards read completions and host memory responses
 */

`timescale 1ns/100ps
`default_nettype none

module tb_host_chan;

    import host_chan_pkg::*;

    logic           clk;
    logic           rst_n;
    logic           rx_valid;
    t_host_chan_rx  rx;
    logic           rx_ready;
    logic           tx_valid;
    t_host_chan_tx  tx;
    logic           tx_ready;
    logic           host_mem_rsp_valid;
    logic [31:0]    host_mem_rsp;

    // Operations from the stimulus file with one entry per line
    byte          op_q[$];
    logic [31:0]  addr_q[$];
    logic [31:0]  data_q[$];
    logic [31:0]  exp_q[$];

    // Scoreboards for read completions and host memory responses
    logic [7:0]   exp_tid_q[$];
    logic [31:0]  exp_rd_q[$];
    logic [31:0]  exp_mem_q[$];
    int           exp_mem_cyc_q[$];

    int           errors;
    int           checks;
    int           cycle;
    int           limit;
    logic [31:0]  rng_state;

    host_chan_as_axil_mmio i_host_chan_as_axil_mmio (
        .clk, .rst_n,
        .rx_valid, .rx, .rx_ready,
        .tx_valid, .tx, .tx_ready,
        .host_mem_rsp_valid, .host_mem_rsp
    );

    bind host_chan_as_axil_mmio tb_host_chan_sva i_sva (.*);

    always #5 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Lines starting with # are comments and every other line holds op, addr, data, expect
    task automatic load_stimulus();
        int           fd;
        int           n;
        string        line;
        byte          op;
        logic [31:0]  a;
        logic [31:0]  d;
        logic [31:0]  e;
        fd = $fopen("host_chan_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file host_chan_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%c %h %h %h", op, a, d, e);
            if (n != 4 || !(op == "W" || op == "R" || op == "M")) begin
                errors++;
                $display("Stimulus line could not be understood: %s", line);
                continue;
            end
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
        end
        $fclose(fd);
    endtask

    // Called on a rising edge and returns on the edge where rx is taken
    task automatic send_op(input int idx);
        t_host_chan_rx  msg;
        logic [7:0]     tid;
        tid = 8'(idx + 32);
        msg.tid = tid;
        msg.addr = addr_q[idx][15:0];
        msg.data = data_q[idx];
        case (op_q[idx])
            "W":     msg.kind = RX_MMIO_WR;
            "R":     msg.kind = RX_MMIO_RD;
            default: msg.kind = RX_MEM_RSP;
        endcase
        rx_valid <= 1'b1;
        rx <= msg;
        @(posedge clk);
        while (!rx_ready) @(posedge clk);
        // A read is owed a completion and a memory response shows up one cycle later
        if (op_q[idx] == "R") begin
            exp_tid_q.push_back(tid);
            exp_rd_q.push_back(exp_q[idx]);
        end else if (op_q[idx] == "M") begin
            exp_mem_q.push_back(data_q[idx]);
            exp_mem_cyc_q.push_back(cycle + 1);
        end
    endtask

    // ==================================================
    // Back-pressure, monitors and watchdog
    // ==================================================

    always @(posedge clk) begin
        rng_state = lcg_next(rng_state);
        tx_ready <= rng_state[31];
    end

    always @(posedge clk) begin
        if (rst_n && tx_valid && tx_ready) begin
            if (exp_tid_q.size() == 0) begin
                errors++;
                $display("A read completion arrived that no read asked for");
            end else begin
                check_value("tx tid", 32'(tx.tid), 32'(exp_tid_q.pop_front()));
                check_value("tx data", tx.data, exp_rd_q.pop_front());
            end
        end
        if (rst_n && host_mem_rsp_valid) begin
            if (exp_mem_q.size() == 0) begin
                errors++;
                $display("A host memory response appeared that was never sent");
            end else begin
                check_value("host_mem_rsp", host_mem_rsp, exp_mem_q.pop_front());
                check_value("host_mem_rsp cycle", 32'(cycle), 32'(exp_mem_cyc_q.pop_front()));
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle);
            $display("Errors found");
            $finish;
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk = 1'b0;
        rst_n = 1'b0;
        rx_valid = 1'b0;
        rx = '0;
        tx_ready = 1'b0;
        errors = 0;
        checks = 0;
        cycle = 0;
        limit = 0;
        rng_state = 32'h4342d099;
        load_stimulus();
        // Watchdog budget of 200 cycles per stimulus line
        limit = 200 * (op_q.size() + 1);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < op_q.size(); i++) begin
            send_op(i);
        end
        rx_valid <= 1'b0;
        while (exp_tid_q.size() != 0 || exp_mem_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_host_chan_sva.sv ====
/*
 * Handshake checks bound into the shim top: payloads hold while
 * stalled, memory response output quiet in reset
 */

`timescale 1ns/100ps
`default_nettype none

module tb_host_chan_sva (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                rx_valid,
    input  wire host_chan_pkg::t_host_chan_rx  rx,
    input  wire                                rx_ready,
    input  wire                                tx_valid,
    input  wire host_chan_pkg::t_host_chan_tx  tx,
    input  wire                                tx_ready,
    input  wire                                host_mem_rsp_valid,
    input  wire                                m_aw_valid,
    input  wire host_chan_pkg::t_axil_aw       m_aw,
    input  wire                                m_aw_ready,
    input  wire                                m_w_valid,
    input  wire host_chan_pkg::t_axil_w        m_w,
    input  wire                                m_w_ready,
    input  wire                                m_b_valid,
    input  wire host_chan_pkg::t_axil_b        m_b,
    input  wire                                m_b_ready,
    input  wire                                m_ar_valid,
    input  wire host_chan_pkg::t_axil_ar       m_ar,
    input  wire                                m_ar_ready,
    input  wire                                m_r_valid,
    input  wire host_chan_pkg::t_axil_r        m_r,
    input  wire                                m_r_ready
);

    // A stalled source keeps valid up and its payload unchanged
    a_rx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx))
        else $error("rx changed while stalled");

    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx))
        else $error("tx changed while stalled");

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
        else $error("AW changed while stalled");

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
        else $error("W changed while stalled");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_b_valid && !m_b_ready |=> m_b_valid && $stable(m_b))
        else $error("B changed while stalled");

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
        else $error("AR changed while stalled");

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_r_valid && !m_r_ready |=> m_r_valid && $stable(m_r))
        else $error("R changed while stalled");

    // The memory response port stays silent while reset is applied
    a_mem_rsp_reset: assert property (@(posedge clk) !rst_n |-> !host_mem_rsp_valid)
        else $error("host_mem_rsp_valid high during reset");

endmodule

`default_nettype wire

// ==== host_chan_as_axil_mmio.sv ====
/*
 * Host channel shim top: splits host memory responses from MMIO and
 * serves MMIO from the accelerator CSRs over sliced AXI4-Lite
 */

`timescale 1ns/100ps
`default_nettype none

module host_chan_as_axil_mmio #(
    parameter int N_REG_STAGES = 1,
    parameter int MAX_OUTSTANDING_RD = 4,
    parameter int N_SCRATCH = 4
) (
    input  wire                                    clk,
    input  wire                                    rst_n,

    input  wire                                    rx_valid,
    input  wire host_chan_pkg::t_host_chan_rx      rx,
    output logic                                   rx_ready,

    output logic                                   tx_valid,
    output host_chan_pkg::t_host_chan_tx           tx,
    input  wire                                    tx_ready,

    output logic                                   host_mem_rsp_valid,
    output logic [host_chan_pkg::MMIO_DATA_W-1:0]  host_mem_rsp
);

    import host_chan_pkg::*;

    t_host_chan_rx  mmio;
    logic           mmio_valid;
    logic           mmio_ready;
    logic           mem_rsp_seen;

    // Mapper side of the AXI4-Lite path carries the m_ prefix, CSR side s_
    t_axil_aw  m_aw;
    t_axil_aw  s_aw;
    t_axil_w   m_w;
    t_axil_w   s_w;
    t_axil_b   m_b;
    t_axil_b   s_b;
    t_axil_ar  m_ar;
    t_axil_ar  s_ar;
    t_axil_r   m_r;
    t_axil_r   s_r;
    logic      m_aw_valid, m_aw_ready, s_aw_valid, s_aw_ready;
    logic      m_w_valid, m_w_ready, s_w_valid, s_w_ready;
    logic      m_b_valid, m_b_ready, s_b_valid, s_b_ready;
    logic      m_ar_valid, m_ar_ready, s_ar_valid, s_ar_ready;
    logic      m_r_valid, m_r_ready, s_r_valid, s_r_ready;

    host_chan_split_mmio split_mmio (
        .clk, .rst_n,
        .rx_valid, .rx, .rx_ready,
        .mmio_valid, .mmio, .mmio_ready,
        .host_mem_rsp_valid, .host_mem_rsp, .mem_rsp_seen
    );

    host_chan_map_mmio_axil #(.MAX_OUTSTANDING_RD(MAX_OUTSTANDING_RD)) map_mmio (
        .clk, .rst_n,
        .mmio_valid, .mmio, .mmio_ready,
        .aw_valid(m_aw_valid), .aw(m_aw), .aw_ready(m_aw_ready),
        .w_valid(m_w_valid), .w(m_w), .w_ready(m_w_ready),
        .b_valid(m_b_valid), .b(m_b), .b_ready(m_b_ready),
        .ar_valid(m_ar_valid), .ar(m_ar), .ar_ready(m_ar_ready),
        .r_valid(m_r_valid), .r(m_r), .r_ready(m_r_ready),
        .tx_valid, .tx, .tx_ready
    );

    // ==================================================
    // Register slices, one per channel in its own direction
    // ==================================================

    axil_reg_stage #(.t_payload(t_axil_aw), .N_REG_STAGES(N_REG_STAGES)) reg_aw (
        .clk, .rst_n,
        .in_valid(m_aw_valid), .in(m_aw), .in_ready(m_aw_ready),
        .out_valid(s_aw_valid), .out(s_aw), .out_ready(s_aw_ready)
    );

    axil_reg_stage #(.t_payload(t_axil_w), .N_REG_STAGES(N_REG_STAGES)) reg_w (
        .clk, .rst_n,
        .in_valid(m_w_valid), .in(m_w), .in_ready(m_w_ready),
        .out_valid(s_w_valid), .out(s_w), .out_ready(s_w_ready)
    );

    // Responses flow from the CSR block back to the mapper
    axil_reg_stage #(.t_payload(t_axil_b), .N_REG_STAGES(N_REG_STAGES)) reg_b (
        .clk, .rst_n,
        .in_valid(s_b_valid), .in(s_b), .in_ready(s_b_ready),
        .out_valid(m_b_valid), .out(m_b), .out_ready(m_b_ready)
    );

    axil_reg_stage #(.t_payload(t_axil_ar), .N_REG_STAGES(N_REG_STAGES)) reg_ar (
        .clk, .rst_n,
        .in_valid(m_ar_valid), .in(m_ar), .in_ready(m_ar_ready),
        .out_valid(s_ar_valid), .out(s_ar), .out_ready(s_ar_ready)
    );

    axil_reg_stage #(.t_payload(t_axil_r), .N_REG_STAGES(N_REG_STAGES)) reg_r (
        .clk, .rst_n,
        .in_valid(s_r_valid), .in(s_r), .in_ready(s_r_ready),
        .out_valid(m_r_valid), .out(m_r), .out_ready(m_r_ready)
    );

    // CSR block sits beside the splitter and counts its memory responses
    afu_csr_regs #(.N_SCRATCH(N_SCRATCH)) csr (
        .clk, .rst_n,
        .aw_valid(s_aw_valid), .aw(s_aw), .aw_ready(s_aw_ready),
        .w_valid(s_w_valid), .w(s_w), .w_ready(s_w_ready),
        .b_valid(s_b_valid), .b(s_b), .b_ready(s_b_ready),
        .ar_valid(s_ar_valid), .ar(s_ar), .ar_ready(s_ar_ready),
        .r_valid(s_r_valid), .r(s_r), .r_ready(s_r_ready),
        .mem_rsp_seen
    );

endmodule

`default_nettype wire

// ==== afu_csr_regs.sv ====
/*
 * Accelerator CSR block on AXI4-Lite: identity, memory response
 * count and byte-enabled scratch registers
 */

`timescale 1ns/100ps
`default_nettype none

module afu_csr_regs #(
    parameter int N_SCRATCH = 4
) (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          aw_valid,
    input  wire host_chan_pkg::t_axil_aw aw,
    output logic                         aw_ready,
    input  wire                          w_valid,
    input  wire host_chan_pkg::t_axil_w  w,
    output logic                         w_ready,
    output logic                         b_valid,
    output host_chan_pkg::t_axil_b       b,
    input  wire                          b_ready,
    input  wire                          ar_valid,
    input  wire host_chan_pkg::t_axil_ar ar,
    output logic                         ar_ready,
    output logic                         r_valid,
    output host_chan_pkg::t_axil_r       r,
    input  wire                          r_ready,

    input  wire                          mem_rsp_seen
);

    import host_chan_pkg::*;

    localparam int WORD_W = MMIO_ADDR_W - 2;

    logic [MMIO_DATA_W-1:0]  scratch [N_SCRATCH];
    logic [MMIO_DATA_W-1:0]  rsp_count;
    logic [MMIO_DATA_W-1:0]  rd_data;
    logic [MMIO_DATA_W-1:0]  rd_data_q;
    logic [WORD_W-1:0]       wr_word;
    logic [WORD_W-1:0]       rd_word;
    logic                    b_free;
    logic                    wr_fire;
    logic                    rd_fire;

    // Register map is word based, low address bits are ignored
    assign wr_word = aw.addr[MMIO_ADDR_W-1:2];
    assign rd_word = ar.addr[MMIO_ADDR_W-1:2];

    // ==================================================
    // Write channel
    // ==================================================

    // AW and W are taken together, once the previous B has gone
    assign b_free = !b_valid || b_ready;
    assign aw_ready = w_valid && b_free;
    assign w_ready = aw_valid && b_free;
    assign wr_fire = aw_valid && w_valid && b_free;
    assign b = '{resp: AXIL_RESP_OKAY};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            rsp_count <= '0;
            for (int i = 0; i < N_SCRATCH; i++) scratch[i] <= '0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (mem_rsp_seen) rsp_count <= rsp_count + 1'b1;
            // Scratch i sits at word 2 + i, writes elsewhere are dropped
            for (int i = 0; i < N_SCRATCH; i++) begin
                if (wr_fire && wr_word == WORD_W'(2 + i)) begin
                    for (int n = 0; n < MMIO_DATA_W / 8; n++) begin
                        if (w.strb[n]) scratch[i][8*n +: 8] <= w.data[8*n +: 8];
                    end
                end
            end
        end
    end

    // ==================================================
    // Read channel
    // ==================================================

    // Unmapped words read as zero
    always_comb begin
        rd_data = '0;
        if (rd_word == WORD_W'(0)) rd_data = CSR_ID_VALUE;
        if (rd_word == WORD_W'(1)) rd_data = rsp_count;
        for (int i = 0; i < N_SCRATCH; i++) begin
            if (rd_word == WORD_W'(2 + i)) rd_data = scratch[i];
        end
    end

    // R is held until taken, which also stalls further AR
    assign ar_ready = !r_valid || r_ready;
    assign rd_fire = ar_valid && ar_ready;
    assign r = '{data: rd_data_q, resp: AXIL_RESP_OKAY};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (rd_fire) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) rd_data_q <= rd_data;
    end

endmodule

`default_nettype wire

// ==== host_chan_map_mmio_axil.sv ====
/*
 * MMIO to AXI4-Lite master that turns host MMIO reads and writes into
 * AXI transactions and returns tid-tagged read completions
 */

`timescale 1ns/100ps
`default_nettype none

module host_chan_map_mmio_axil #(
    parameter int MAX_OUTSTANDING_RD = 4
) (
    input  wire                                clk,
    input  wire                                rst_n,

    input  wire                                mmio_valid,
    input  wire host_chan_pkg::t_host_chan_rx  mmio,
    output logic                               mmio_ready,

    output logic                               aw_valid,
    output host_chan_pkg::t_axil_aw            aw,
    input  wire                                aw_ready,
    output logic                               w_valid,
    output host_chan_pkg::t_axil_w             w,
    input  wire                                w_ready,
    input  wire                                b_valid,
    input  wire host_chan_pkg::t_axil_b        b,
    output logic                               b_ready,
    output logic                               ar_valid,
    output host_chan_pkg::t_axil_ar            ar,
    input  wire                                ar_ready,
    input  wire                                r_valid,
    input  wire host_chan_pkg::t_axil_r        r,
    output logic                               r_ready,

    output logic                               tx_valid,
    output host_chan_pkg::t_host_chan_tx       tx,
    input  wire                                tx_ready
);

    import host_chan_pkg::*;

    localparam int PTR_W = (MAX_OUTSTANDING_RD > 1) ? $clog2(MAX_OUTSTANDING_RD) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING_RD + 1);

    logic              wr_pending;
    logic [CNT_W-1:0]  rd_cnt;
    logic [TID_W-1:0]  tid_fifo [MAX_OUTSTANDING_RD];
    logic [PTR_W-1:0]  tid_wr_ptr;
    logic [PTR_W-1:0]  tid_rd_ptr;
    logic              is_wr;
    logic              wr_ok;
    logic              rd_ok;
    logic              wr_accept;
    logic              rd_accept;
    logic              r_fire;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MAX_OUTSTANDING_RD - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ==================================================
    // Acceptance and ordering
    // ==================================================

    // Writes wait for all reads to drain, reads wait behind a pending write,
    // so every read sees the effect of all earlier writes
    assign is_wr = (mmio.kind == RX_MMIO_WR);
    assign wr_ok = !wr_pending && (rd_cnt == '0);
    // A new AR can only be loaded once the previous one leaves this cycle
    assign rd_ok = !wr_pending && (rd_cnt < CNT_W'(MAX_OUTSTANDING_RD)) &&
                   (!ar_valid || ar_ready);

    assign mmio_ready = is_wr ? wr_ok : rd_ok;
    assign wr_accept = mmio_valid && is_wr && wr_ok;
    assign rd_accept = mmio_valid && !is_wr && rd_ok;

    // ==================================================
    // Write path
    // ==================================================

    // Only one write is ever in flight, so B is taken whenever one is pending
    assign b_ready = wr_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pending <= 1'b0;
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
        end else if (wr_accept) begin
            wr_pending <= 1'b1;
            aw_valid <= 1'b1;
            w_valid <= 1'b1;
        end else begin
            if (aw_ready) aw_valid <= 1'b0;
            if (w_ready) w_valid <= 1'b0;
            // The write retires on B whatever its response code
            if (b_valid) wr_pending <= 1'b0;
        end
    end

    // Full 32 bit writes only with all byte strobes set
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            aw.addr <= mmio.addr;
            aw.prot <= '0;
            w.data <= mmio.data;
            w.strb <= '1;
        end
    end

    // ==================================================
    // Read path
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
        end else if (rd_accept) begin
            ar_valid <= 1'b1;
        end else if (ar_ready) begin
            ar_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            ar.addr <= mmio.addr;
            ar.prot <= '0;
            tid_fifo[tid_wr_ptr] <= mmio.tid;
        end
    end

    // Completions are in order, so the oldest tid belongs to the next R
    assign r_fire = r_valid && r_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tid_wr_ptr <= '0;
            tid_rd_ptr <= '0;
            rd_cnt <= '0;
        end else begin
            if (rd_accept) tid_wr_ptr <= next_ptr(tid_wr_ptr);
            if (r_fire) tid_rd_ptr <= next_ptr(tid_rd_ptr);
            rd_cnt <= rd_cnt + CNT_W'(rd_accept) - CNT_W'(r_fire);
        end
    end

    // ==================================================
    // Completion register
    // ==================================================

    // R stalls while the host holds back a completion, which backs up the slices
    assign r_ready = !tx_valid || tx_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
        end else if (r_fire) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    // A failed read returns all ones to the host
    always_ff @(posedge clk) begin
        if (r_fire) begin
            tx.tid <= tid_fifo[tid_rd_ptr];
            tx.data <= (r.resp == AXIL_RESP_OKAY) ? r.data : '1;
        end
    end

endmodule

`default_nettype wire

// ==== host_chan_split_mmio.sv ====
/*
 * Host channel splitter: MMIO requests go on to the mapper,
 * host memory responses leave on their own registered port
 */

`timescale 1ns/100ps
`default_nettype none

module host_chan_split_mmio (
    input  wire                                    clk,
    input  wire                                    rst_n,

    input  wire                                    rx_valid,
    input  wire host_chan_pkg::t_host_chan_rx      rx,
    output logic                                   rx_ready,

    output logic                                   mmio_valid,
    output host_chan_pkg::t_host_chan_rx           mmio,
    input  wire                                    mmio_ready,

    output logic                                   host_mem_rsp_valid,
    output logic [host_chan_pkg::MMIO_DATA_W-1:0]  host_mem_rsp,
    output logic                                   mem_rsp_seen
);

    import host_chan_pkg::*;

    logic is_mem_rsp;

    assign is_mem_rsp = (rx.kind == RX_MEM_RSP);

    // Everything that is not a memory response is an MMIO request
    assign mmio_valid = rx_valid && !is_mem_rsp;
    assign mmio = rx;

    // Memory responses are never stalled, MMIO waits for the mapper
    assign rx_ready = is_mem_rsp ? 1'b1 : mmio_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_mem_rsp_valid <= 1'b0;
        end else begin
            host_mem_rsp_valid <= rx_valid && is_mem_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && is_mem_rsp) begin
            host_mem_rsp <= rx.data;
        end
    end

    // The CSR block counts one pulse per response passed
    assign mem_rsp_seen = host_mem_rsp_valid;

endmodule

`default_nettype wire

// ==== axil_reg_stage.sv ====
/*
 * Register slice for one AXI4-Lite channel: a chain of valid/ready
 * pipeline registers, full throughput, payload given as a type
 */

`timescale 1ns/100ps
`default_nettype none

module axil_reg_stage #(
    parameter type t_payload = logic,
    parameter int  N_REG_STAGES = 1
) (
    input  wire       clk,
    input  wire       rst_n,

    input  wire       in_valid,
    input  wire       t_payload in,
    output logic      in_ready,

    output logic      out_valid,
    output t_payload  out,
    input  wire       out_ready
);

    // Index 0 is the input port, index N_REG_STAGES is the last register
    logic      valid [0:N_REG_STAGES];
    logic      ready [0:N_REG_STAGES];
    t_payload  data  [0:N_REG_STAGES];

    assign valid[0] = in_valid;
    assign data[0] = in;
    assign in_ready = ready[0];

    assign out_valid = valid[N_REG_STAGES];
    assign out = data[N_REG_STAGES];
    assign ready[N_REG_STAGES] = out_ready;

    // With zero stages the loop is empty and the channel is a plain wire
    for (genvar i = 0; i < N_REG_STAGES; i++) begin : g_stage
        // A stage takes new data when empty or when it drains in the same cycle
        assign ready[i] = !valid[i+1] || ready[i+1];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid[i+1] <= 1'b0;
            end else if (ready[i]) begin
                valid[i+1] <= valid[i];
            end
        end

        // Payload only moves on a real transfer into this stage
        always_ff @(posedge clk) begin
            if (ready[i] && valid[i]) begin
                data[i+1] <= data[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== host_chan_pkg.sv ====
/*
 * Host-channel shim shared types: incoming message, read completion,
 * fixed MMIO widths and the five AXI4-Lite channel payloads
 */

`default_nettype none

package host_chan_pkg;

    // ==================================================
    // Fixed widths and constants
    // ==================================================

    // MMIO is byte addressed, 32 bit data only
    localparam int MMIO_ADDR_W = 16;
    localparam int MMIO_DATA_W = 32;
    localparam int TID_W = 8;

    // Value returned by the identity register at offset 0x0
    localparam logic [31:0] CSR_ID_VALUE = 32'h4843_4d31;

    // AXI response code, only OKAY is ever generated by the CSR block
    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // ==================================================
    // Host channel messages
    // ==================================================

    // Kind of message carried on the incoming host stream
    typedef enum logic [1:0] {
        RX_MMIO_RD = 2'd0,
        RX_MMIO_WR = 2'd1,
        RX_MEM_RSP = 2'd2
    } t_rx_kind;

    // One incoming message, data is write data or host memory response data
    typedef struct packed {
        t_rx_kind                kind;
        logic [TID_W-1:0]        tid;
        logic [MMIO_ADDR_W-1:0]  addr;
        logic [MMIO_DATA_W-1:0]  data;
    } t_host_chan_rx;

    // MMIO read completion returned to the host
    typedef struct packed {
        logic [TID_W-1:0]        tid;
        logic [MMIO_DATA_W-1:0]  data;
    } t_host_chan_tx;

    // ==================================================
    // AXI4-Lite channel payloads
    // ==================================================

    typedef struct packed {
        logic [MMIO_ADDR_W-1:0]  addr;
        logic [2:0]              prot;
    } t_axil_aw;

    typedef struct packed {
        logic [MMIO_ADDR_W-1:0]  addr;
        logic [2:0]              prot;
    } t_axil_ar;

    typedef struct packed {
        logic [MMIO_DATA_W-1:0]    data;
        logic [MMIO_DATA_W/8-1:0]  strb;
    } t_axil_w;

    typedef struct packed {
        logic [1:0]  resp;
    } t_axil_b;

    typedef struct packed {
        logic [MMIO_DATA_W-1:0]  data;
        logic [1:0]              resp;
    } t_axil_r;

endpackage

`default_nettype wire
